// ==== design/botFifo.sv ====
`default_nettype none

module botFifo import pipelinePkg::*; (
    input logic clk,
    input logic rstN,
    permLink.fifoSide inLink,
    coreLink.fifoSide outLink
);

    botT botMem [fifoDepth];
    addrT addrMem [fifoDepth];

    logic [$clog2(fifoDepth)-1:0] wrPtr;
    logic [$clog2(fifoDepth)-1:0] rdPtr;
    // one extra bit so a full buffer is distinguishable from empty
    logic [$clog2(fifoDepth):0] fill;
    logic doWrite;
    logic doRead;

    assign doWrite = inLink.botValid;
    assign doRead = outLink.readRequest && (fill != '0);

    always_ff @(posedge clk) begin
        if (doWrite) begin
            botMem[wrPtr] <= inLink.bot;
            addrMem[wrPtr] <= inLink.addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            fill <= fill + (doWrite ? 1'b1 : 1'b0) - (doRead ? 1'b1 : 1'b0);
        end
    end

    // registered read port
    always_ff @(posedge clk) begin
        if (doRead) begin
            outLink.bot <= botMem[rdPtr];
            outLink.addr <= addrMem[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outLink.dataValid <= 1'b0;
        end else begin
            outLink.dataValid <= doRead;
        end
    end

    // level saturates, a completely full buffer reads as 31
    assign inLink.level = fill[$clog2(fifoDepth)] ? '1 : fifoLevelT'(fill);

    noOverflow: assert property (@(posedge clk) disable iff (!rstN)
        inLink.botValid |-> fill != fifoDepth);

endmodule

`default_nettype wire

// ==== design/botPermuter.sv ====
`default_nettype none

module botPermuter import pipelinePkg::*; (
    input logic clk,
    input logic rstN,
    input botT bot,
    input addrT botIndex,
    input logic isBotValid,
    input permMaskT validBotPermutations,
    permLink.permSide link
);

    // input delay line
    botT botD [inputDelay];
    addrT addrD [inputDelay];
    permMaskT maskD [inputDelay];
    logic [inputDelay-1:0] validD;

    permState state;
    permMaskT remMask;
    permMaskT nextMask;
    botT botHold;
    addrT addrHold;
    logic [2:0] permSel;

    // rearranges index bits 4..6 of the truth table per permutation k
    function automatic botT permuteBot(botT in, logic [2:0] k);
        botT res;
        logic [6:0] i;
        logic [6:0] j;
        for (int n = 0; n < botWidth; n++) begin
            i = 7'(n);
            j = i;
            case (k)
                3'd1: j[6:4] = {i[5], i[6], i[4]};
                3'd2: j[6:4] = {i[6], i[4], i[5]};
                3'd3: j[6:4] = {i[5], i[4], i[6]};
                3'd4: j[6:4] = {i[4], i[6], i[5]};
                3'd5: j[6:4] = {i[4], i[5], i[6]};
                default: j = i;
            endcase
            res[n] = in[j];
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        botD[0] <= bot;
        addrD[0] <= botIndex;
        maskD[0] <= validBotPermutations;
        for (int s = 1; s < inputDelay; s++) begin
            botD[s] <= botD[s-1];
            addrD[s] <= addrD[s-1];
            maskD[s] <= maskD[s-1];
        end
    end

    // a strobe with an empty mask is dropped here
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validD <= '0;
        end else begin
            validD <= {validD[inputDelay-2:0], isBotValid & (|validBotPermutations)};
        end
    end

    // lowest pending permutation goes first
    always_comb begin
        permSel = 3'd0;
        for (int k = 5; k >= 0; k--) begin
            if (remMask[k]) begin
                permSel = 3'(k);
            end
        end
    end

    assign nextMask = remMask & (remMask - permMaskT'(1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= permIdle;
            remMask <= '0;
        end else begin
            case (state)
                permIdle: begin
                    if (validD[inputDelay-1]) begin
                        state <= permBurst;
                        remMask <= maskD[inputDelay-1];
                    end
                end
                permBurst: begin
                    remMask <= nextMask;
                    if (nextMask == '0) begin
                        state <= permIdle;
                    end
                end
                default: state <= permIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == permIdle && validD[inputDelay-1]) begin
            botHold <= botD[inputDelay-1];
            addrHold <= addrD[inputDelay-1];
        end
    end

    assign link.botValid = (state == permBurst);
    assign link.bot = permuteBot(botHold, permSel);
    assign link.addr = addrHold;

    // source spacing rule, otherwise the new bot is lost
    burstOverlap: assert property (@(posedge clk) disable iff (!rstN)
        validD[inputDelay-1] |-> state == permIdle);

endmodule

`default_nettype wire

// ==== design/countCore.sv ====
`default_nettype none

module countCore import pipelinePkg::*; (
    input logic clk,
    input logic rstN,
    input botT top,
    coreLink.coreSide link,
    output logic done,
    output countT count,
    output addrT addr
);

    coreState state;
    botT botHold;
    logic [$clog2(beatCount)-1:0] beat;
    countT acc;
    logic [31:0] overlap;

    // nonzero nibbles in one 32-bit slice
    function automatic countT nibbleCount(logic [31:0] x);
        countT n;
        n = '0;
        for (int q = 0; q < 8; q++) begin
            if (x[4*q +: 4] != 4'h0) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign overlap = top[32*beat +: 32] & botHold[32*beat +: 32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= coreIdle;
            beat <= '0;
            acc <= '0;
        end else begin
            case (state)
                coreIdle: state <= coreWait;
                coreWait: begin
                    // empty FIFO gives no data so ask again
                    if (link.dataValid) begin
                        state <= coreRun;
                        beat <= '0;
                        acc <= '0;
                    end else begin
                        state <= coreIdle;
                    end
                end
                coreRun: begin
                    acc <= acc + nibbleCount(overlap);
                    beat <= beat + 1'b1;
                    if (beat == beatCount - 1) begin
                        state <= coreFinish;
                    end
                end
                coreFinish: state <= coreIdle;
                default: state <= coreIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == coreWait && link.dataValid) begin
            botHold <= link.bot;
            addr <= link.addr;
        end
    end

    assign link.readRequest = (state == coreIdle);
    assign done = (state == coreFinish);
    assign count = acc;

    // data only arrives while the core waits for it
    validInWait: assert property (@(posedge clk) disable iff (!rstN)
        link.dataValid |-> state == coreWait);

endmodule

`default_nettype wire

// ==== design/countPipeline.sv ====
`default_nettype none

module countPipeline import pipelinePkg::*; (
    input logic clk,
    input logic rstN,
    input botT top,
    input botT bot,
    input addrT botIndex,
    input logic isBotValid,
    input permMaskT validBotPermutations,
    output fifoLevelT fifoFullness,
    output sumT summedDataOut,
    output coeffCountT pcoeffCountOut
);

    permLink permLinkI ();
    coreLink coreLinkI ();

    logic coreDone;
    countT coreCount;
    addrT coreAddr;

    botPermuter permuter (
        .clk(clk),
        .rstN(rstN),
        .bot(bot),
        .botIndex(botIndex),
        .isBotValid(isBotValid),
        .validBotPermutations(validBotPermutations),
        .link(permLinkI.permSide)
    );

    botFifo fifo (
        .clk(clk),
        .rstN(rstN),
        .inLink(permLinkI.fifoSide),
        .outLink(coreLinkI.fifoSide)
    );

    countCore core (
        .clk(clk),
        .rstN(rstN),
        .top(top),
        .link(coreLinkI.coreSide),
        .done(coreDone),
        .count(coreCount),
        .addr(coreAddr)
    );

    // botIndex doubles as the read address
    resultCollector collector (
        .clk(clk),
        .rstN(rstN),
        .done(coreDone),
        .count(coreCount),
        .addr(coreAddr),
        .readAddr(botIndex),
        .summedDataOut(summedDataOut),
        .pcoeffCount(pcoeffCountOut)
    );

    assign fifoFullness = permLinkI.level;

endmodule

`default_nettype wire

// ==== design/pipelineIfs.sv ====
`default_nettype none

// permuter to FIFO, one copy per cycle while botValid is high
interface permLink import pipelinePkg::*; ();
    logic botValid;
    botT bot;
    addrT addr;
    fifoLevelT level;

    modport permSide (
        output botValid, bot, addr
    );

    modport fifoSide (
        input botValid, bot, addr,
        output level
    );
endinterface

// FIFO to core, dataValid one cycle after an accepted readRequest
interface coreLink import pipelinePkg::*; ();
    logic readRequest;
    logic dataValid;
    botT bot;
    addrT addr;

    modport fifoSide (
        input readRequest,
        output dataValid, bot, addr
    );

    modport coreSide (
        output readRequest,
        input dataValid, bot, addr
    );
endinterface

`default_nettype wire

// ==== design/pipelinePkg.sv ====
`default_nettype none

package pipelinePkg;

    // widths
    localparam int addrWidth = 4;
    localparam int botWidth = 128;

    // pipeline latencies and sizes
    localparam int inputDelay = 2;
    localparam int fifoDepth = 32;
    localparam int beatCount = 4;

    // source may send a new bot while the fill level is at or below this
    localparam int readyLevel = 16;

    // truth table of seven variables
    typedef logic [botWidth-1:0] botT;
    typedef logic [addrWidth-1:0] addrT;

    // bit k requests permutation k of variables 4, 5 and 6
    typedef logic [5:0] permMaskT;

    typedef logic [5:0] countT;
    typedef logic [37:0] sumT;
    typedef logic [2:0] coeffCountT;
    typedef logic [4:0] fifoLevelT;

    typedef enum logic {
        permIdle,
        permBurst
    } permState;

    typedef enum logic [1:0] {
        coreIdle,
        coreWait,
        coreRun,
        coreFinish
    } coreState;

endpackage

`default_nettype wire

// ==== design/resultCollector.sv ====
`default_nettype none

module resultCollector import pipelinePkg::*; (
    input logic clk,
    input logic rstN,
    input logic done,
    input countT count,
    input addrT addr,
    input addrT readAddr,
    output sumT summedDataOut,
    output coeffCountT pcoeffCount
);

    sumT sums [2**addrWidth];
    coeffCountT coeffs [2**addrWidth];

    // accumulation table, cleared so every address starts at zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int e = 0; e < 2**addrWidth; e++) begin
                sums[e] <= '0;
                coeffs[e] <= '0;
            end
        end else if (done) begin
            sums[addr] <= sums[addr] + sumT'(count);
            // contribution count sticks at 7
            if (coeffs[addr] != '1) begin
                coeffs[addr] <= coeffs[addr] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        summedDataOut <= sums[readAddr];
        pcoeffCount <= coeffs[readAddr];
    end

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`default_nettype none

module clockGen #(
    parameter int periodNs = 100,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2) clk = ~clk;
        end
    end

    // reset released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/countPipelineTb.sv ====
`default_nettype none

module countPipelineTb import pipelinePkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 100;
    localparam int botGap = 12;
    localparam int drainSettle = 20;
    // every copy holds the core for seven cycles
    localparam int drainLimit = 8 * fifoDepth;
    localparam int idBots = 10;
    localparam int randBots = 24;
    localparam int rejectStrobes = 4;
    localparam int idleDataCycles = 4;
    localparam int fillBots = 4;
    localparam int totalBots = idBots + 1 + randBots + rejectStrobes + fillBots;
    localparam int timeoutCycles = 200 * totalBots + 1000;

    logic clk;
    logic rstN;
    botT top;
    botT bot;
    addrT botIndex;
    logic isBotValid;
    permMaskT validBotPermutations;
    fifoLevelT fifoFullness;
    sumT summedDataOut;
    coeffCountT pcoeffCountOut;

    // expected collector contents
    sumT modelSum [16];
    int modelCoeff [16];
    addrT readQ [$];
    int errorCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    fifoLevelT maxLevel;

    clockGen #(.periodNs(clkPeriod), .resetCycles(3)) clocks (
        .clk(clk),
        .rstN(rstN)
    );

    countPipeline countPipeline_i (
        .clk(clk),
        .rstN(rstN),
        .top(top),
        .bot(bot),
        .botIndex(botIndex),
        .isBotValid(isBotValid),
        .validBotPermutations(validBotPermutations),
        .fifoFullness(fifoFullness),
        .summedDataOut(summedDataOut),
        .pcoeffCountOut(pcoeffCountOut)
    );

    // position p of order k names the slot that variable 4+p moves to
    function automatic int letterAt(int k, int p);
        string s;
        case (k)
            1: s = "ACB";
            2: s = "BAC";
            3: s = "BCA";
            4: s = "CAB";
            5: s = "CBA";
            default: s = "ABC";
        endcase
        return int'(s.getc(p)) - int'("A");
    endfunction

    function automatic botT permuteRef(botT in, int k);
        botT res;
        int j;
        for (int i = 0; i < 128; i++) begin
            j = i & 15;
            for (int p = 0; p < 3; p++) begin
                if (((i >> (4 + p)) & 1) != 0) begin
                    j = j | (1 << (4 + letterAt(k, p)));
                end
            end
            res[i] = in[j];
        end
        return res;
    endfunction

    // nibbles where both tables have at least one common bit
    function automatic int nibbleOverlap(botT a, botT b);
        int n;
        n = 0;
        for (int q = 0; q < 32; q++) begin
            if ((a[4*q +: 4] & b[4*q +: 4]) != 4'h0) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic botT randomBot();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic recordBot(botT b, addrT a, permMaskT m);
        for (int k = 0; k < 6; k++) begin
            if (m[k]) begin
                modelSum[a] = modelSum[a] + sumT'(nibbleOverlap(top, permuteRef(b, k)));
                if (modelCoeff[a] < 7) begin
                    modelCoeff[a]++;
                end
            end
        end
    endtask

    task automatic sendBot(botT b, addrT a, permMaskT m);
        @(negedge clk);
        while (fifoFullness > readyLevel) begin
            @(negedge clk);
        end
        bot = b;
        botIndex = a;
        validBotPermutations = m;
        isBotValid = 1'b1;
        @(negedge clk);
        isBotValid = 1'b0;
        recordBot(b, a, m);
        repeat (botGap - 1) begin
            @(negedge clk);
            if (fifoFullness > maxLevel) begin
                maxLevel = fifoFullness;
            end
        end
    endtask

    task automatic waitDrain();
        @(negedge clk);
        while (fifoFullness != 0) begin
            @(negedge clk);
        end
        repeat (drainSettle) @(negedge clk);
    endtask

    // the compare process picks up each address one cycle later
    task automatic readAll();
        for (int a = 0; a < 16; a++) begin
            @(negedge clk);
            botIndex = addrT'(a);
            readQ.push_back(addrT'(a));
        end
        repeat (3) @(negedge clk);
    endtask

    task automatic finishTest(int num, string name, int startErrors);
        waitDrain();
        readAll();
        testsRun++;
        if (errorCount == startErrors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: %0d mismatches", num, name, errorCount - startErrors);
        end
    endtask

    initial begin
        addrT a;
        forever begin
            @(posedge clk);
            if (readQ.size() != 0) begin
                a = readQ.pop_front();
                @(negedge clk);
                assert (summedDataOut == modelSum[a]) else begin
                    $display("FAILED at %0t ns: address %0d sum %0d, expected %0d",
                        $time, a, summedDataOut, modelSum[a]);
                    errorCount++;
                end
                assert (int'(pcoeffCountOut) == modelCoeff[a]) else begin
                    $display("FAILED at %0t ns: address %0d contributions %0d, expected %0d",
                        $time, a, pcoeffCountOut, modelCoeff[a]);
                    errorCount++;
                end
            end
        end
    end

    initial begin
        #(timeoutCycles * clkPeriod);
        $display("timeout: the run did not finish within %0d cycles", timeoutCycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int startErrors;
        addrT a;
        permMaskT m;
        int room;
        int drainWait;
        void'($urandom(68143));
        top = randomBot();
        bot = '0;
        botIndex = '0;
        isBotValid = 1'b0;
        validBotPermutations = '0;
        maxLevel = '0;
        for (int e = 0; e < 16; e++) begin
            modelSum[e] = '0;
            modelCoeff[e] = 0;
        end
        wait (rstN === 1'b1);
        @(negedge clk);

        startErrors = errorCount;
        finishTest(1, "after reset", startErrors);

        startErrors = errorCount;
        for (int n = 0; n < idBots; n++) begin
            sendBot(randomBot(), addrT'(n), 6'b000001);
        end
        finishTest(2, "identity mask", startErrors);

        startErrors = errorCount;
        sendBot(randomBot(), 4'd15, 6'b111111);
        finishTest(3, "full mask", startErrors);

        // addresses 0 to 14 with at most seven contributions each
        startErrors = errorCount;
        for (int n = 0; n < randBots; n++) begin
            a = addrT'($urandom_range(14, 0));
            m = permMaskT'($urandom_range(63, 1));
            for (int t = 0; t < 15 && modelCoeff[a] == 7; t++) begin
                a = (a == 4'd14) ? 4'd0 : a + 4'd1;
            end
            room = 7 - modelCoeff[a];
            if (room > 0) begin
                while ($countones(m) > room) begin
                    m = m & (m - 6'd1);
                end
                sendBot(randomBot(), a, m);
            end
        end
        finishTest(4, "random traffic", startErrors);

        startErrors = errorCount;
        for (int n = 0; n < rejectStrobes; n++) begin
            sendBot(randomBot(), addrT'($urandom_range(15, 0)), '0);
        end
        // data with a mask but no strobe
        for (int n = 0; n < idleDataCycles; n++) begin
            @(negedge clk);
            bot = randomBot();
            botIndex = addrT'($urandom_range(15, 0));
            validBotPermutations = permMaskT'($urandom_range(63, 1));
        end
        @(negedge clk);
        validBotPermutations = '0;
        finishTest(5, "zero-valid rejection", startErrors);

        startErrors = errorCount;
        maxLevel = '0;
        for (int n = 0; n < fillBots; n++) begin
            sendBot(randomBot(), 4'd15, 6'b111111);
        end
        assert (maxLevel > 0) else begin
            $display("the FIFO fill level stayed at zero during the burst");
            errorCount++;
        end
        drainWait = 0;
        while (fifoFullness != 0 && drainWait < drainLimit) begin
            @(negedge clk);
            drainWait++;
        end
        assert (fifoFullness == 0) else begin
            $display("FAILED at %0t ns: fill level %0d after %0d drain cycles, expected 0",
                $time, fifoFullness, drainWait);
            errorCount++;
        end
        finishTest(6, "fill level", startErrors);

        $display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed,
            errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/pipelinePkg.sv
design/pipelineIfs.sv
design/botPermuter.sv
design/botFifo.sv
design/countCore.sv
design/resultCollector.sv
design/countPipeline.sv
sim/clockGen.sv
sim/countPipelineTb.sv
